//--- files.f
lms_frontend_pkg.sv
lms_rx_iq_demux.sv
lms_tx_iq_interleave.sv
lms_spi_router.sv
lms_frontend_top.sv
tb_clock_gen.sv
lms_frontend_properties.sv
lms_frontend_tb.sv

//--- lms_frontend_tb.sv
// Testbench for the LMS front end
// Applies a seeded stimulus table one row per cycle and checks
// receive demux, transmit interleave and SPI routing

`timescale 1ns/1ps

module lms_frontend_tb
   import lms_frontend_pkg::*;
();

   localparam int NUM_ROWS      = 24;
   localparam int CLK_PERIOD_NS = 10;
   localparam int WATCHDOG_NS   = (NUM_ROWS * 2 + 20) * CLK_PERIOD_NS;
   localparam int SEED          = 44;

   typedef struct packed
   {
      lms_port_t  [NUM_CH-1:0]          rx;
      iq_sample_t [NUM_CH-1:0]          tx;     // Same pair on rows 2k and 2k+1
      spi_bus_t                         spi;
      logic [NUM_SPI_TARGETS-1:0]       sen_n;
      logic [NUM_SPI_TARGETS-1:0]       miso;
   } stim_row_t;

   logic                       dsp_clk;
   logic                       reset_i;
   lms_port_t                  rx_port_i   [NUM_CH];
   iq_sample_t                 rx_sample_o [NUM_CH];
   iq_sample_t                 tx_sample_i [NUM_CH];
   lms_port_t                  tx_port_o   [NUM_CH];
   spi_bus_t                   spi_i;
   logic [NUM_SPI_TARGETS-1:0] spi_sen_n_i;
   logic                       spi_miso_o;
   logic [NUM_SPI_TARGETS-1:0] spi_target_miso_i;
   spi_bus_t                   spi_dac_o;
   spi_bus_t                   spi_lms_o [2];

   stim_row_t  stim_table [NUM_ROWS];
   iq_sample_t exp_rx [NUM_CH];   // Receive model
   logic       tx_phase;          // Transmit model phase

   tb_clock_gen u_clk_gen (.dsp_clk_o(dsp_clk), .reset_o(reset_i));

   lms_frontend_top dut0
   (
      .dsp_clk           (dsp_clk),
      .reset_i           (reset_i),
      .rx_port_i         (rx_port_i),
      .rx_sample_o       (rx_sample_o),
      .tx_sample_i       (tx_sample_i),
      .tx_port_o         (tx_port_o),
      .spi_i             (spi_i),
      .spi_sen_n_i       (spi_sen_n_i),
      .spi_miso_o        (spi_miso_o),
      .spi_target_miso_i (spi_target_miso_i),
      .spi_dac_o         (spi_dac_o),
      .spi_lms_o         (spi_lms_o)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic build_table();
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            stim_table[r].rx[ch].d = $urandom() % 4096;
            if (r % 2 == 0)
            begin
               stim_table[r].tx[ch].i = $urandom() % 4096;
               stim_table[r].tx[ch].q = $urandom() % 4096;
            end
            else
            begin
               stim_table[r].tx[ch] = stim_table[r-1].tx[ch];   // Pair held two cycles
            end
         end
         stim_table[r].rx[0].iqsel = r % 2;         // Alternating selects
         stim_table[r].rx[1].iqsel = (r / 3) % 2;   // Runs of three
         stim_table[r].spi.sclk    = $urandom() % 2;
         stim_table[r].spi.mosi    = $urandom() % 2;
         stim_table[r].sen_n       = r % 8;         // Every select vector
         stim_table[r].miso        = $urandom() % 8;
      end
   endtask

   task automatic drive_row(input int r);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         rx_port_i[ch]   = stim_table[r].rx[ch];
         tx_sample_i[ch] = stim_table[r].tx[ch];
      end
      spi_i             = stim_table[r].spi;
      spi_sen_n_i       = stim_table[r].sen_n;
      spi_target_miso_i = stim_table[r].miso;
   endtask

   task automatic check_reset_state();
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         check_value($sformatf("tx_port_o[%0d].d", ch), 0, tx_port_o[ch].d);
         check_value($sformatf("tx_port_o[%0d].iqsel", ch), 1, tx_port_o[ch].iqsel);
         check_value($sformatf("rx_sample_o[%0d]", ch), 0, rx_sample_o[ch]);
      end
   endtask

   task automatic check_spi(input int r);
      stim_row_t row;
      spi_bus_t  exp_bus;
      logic      exp_miso;
      row = stim_table[r];
      exp_bus.sclk = row.spi.sclk;   // DAC clock is never gated
      exp_bus.mosi = row.sen_n[SPI_DAC] ? 1'b0 : row.spi.mosi;
      check_value("spi_dac_o", exp_bus, spi_dac_o);
      exp_bus = row.sen_n[SPI_LMS1] ? 2'b00 : row.spi;
      check_value("spi_lms_o[0]", exp_bus, spi_lms_o[0]);
      exp_bus = row.sen_n[SPI_LMS2] ? 2'b00 : row.spi;
      check_value("spi_lms_o[1]", exp_bus, spi_lms_o[1]);
      exp_miso = 1'b0;
      for (int t = 0; t < NUM_SPI_TARGETS; t++)
      begin
         if (!row.sen_n[t])
         begin
            exp_miso = exp_miso | row.miso[t];
         end
      end
      check_value("spi_miso_o", exp_miso, spi_miso_o);
   endtask

   // Model the edge that sampled row r and compare registered outputs
   task automatic check_edge(input int r);
      lms_port_t exp_port;
      tx_phase = ~tx_phase;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (stim_table[r].rx[ch].iqsel)
         begin
            exp_rx[ch].q = stim_table[r].rx[ch].d;
         end
         else
         begin
            exp_rx[ch].i = stim_table[r].rx[ch].d;
         end
         exp_port.d     = tx_phase ? stim_table[r].tx[ch].i : stim_table[r].tx[ch].q;
         exp_port.iqsel = ~tx_phase;
         check_value($sformatf("rx_sample_o[%0d].i", ch), exp_rx[ch].i, rx_sample_o[ch].i);
         check_value($sformatf("rx_sample_o[%0d].q", ch), exp_rx[ch].q, rx_sample_o[ch].q);
         check_value($sformatf("tx_port_o[%0d]", ch), exp_port, tx_port_o[ch]);
      end
   endtask

   initial
   begin
      #WATCHDOG_NS;
      $display("Watchdog expired before the stimulus table finished");
      $display("TEST FAIL");
      $fatal(1, "Timeout");
   end

   initial
   begin
      void'($urandom(SEED));
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         rx_port_i[ch]   = '0;
         tx_sample_i[ch] = '0;
         exp_rx[ch]      = '0;
      end
      spi_i             = '0;
      spi_sen_n_i       = '1;   // Nothing selected
      spi_target_miso_i = '0;
      tx_phase          = 1'b0;
      build_table();

      // Reset drops just after the third of these edges
      repeat (3)
      begin
         @(posedge dsp_clk);
         #1;
         check_reset_state();
      end
      wait (reset_i == 1'b0);

      for (int r = 0; r < NUM_ROWS; r++)
      begin
         drive_row(r);
         #1;
         check_spi(r);
         @(posedge dsp_clk);
         #1;
         check_edge(r);
      end

      if (dut0.u_props.fail_count == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
      begin
         $display("Bound assertions failed %0d times", dut0.u_props.fail_count);
         $display("TEST FAIL");
         $fatal(1, "Assertion failures");
      end
   end

endmodule

//--- lms_frontend_properties.sv
// Concurrent checks on the LMS front end
// Transmit select toggling, SPI clock gating and receive field hold

`timescale 1ns/1ps

module lms_frontend_properties
   import lms_frontend_pkg::*;
(
   input logic                       dsp_clk,
   input logic                       reset_i,
   input lms_port_t                  rx_port_i   [NUM_CH],
   input iq_sample_t                 rx_sample_o [NUM_CH],
   input lms_port_t                  tx_port_o   [NUM_CH],
   input logic [NUM_SPI_TARGETS-1:0] spi_sen_n_i,
   input spi_bus_t                   spi_lms_o   [2]
);

   int unsigned fail_count = 0;   // Failed assertion count

   for (genvar ch = 0; ch < NUM_CH; ch++)
   begin : g_ch
      // Select alternates every cycle once out of reset
      a_tx_toggle : assert property (@(posedge dsp_clk) disable iff (reset_i)
         !$past(reset_i) |-> (tx_port_o[ch].iqsel != $past(tx_port_o[ch].iqsel)))
         else
         begin
            fail_count++;
            $error("tx_port_o[%0d].iqsel did not toggle", ch);
         end

      a_rx_i_hold : assert property (@(posedge dsp_clk) disable iff (reset_i)
         (!$past(reset_i) && $past(rx_port_i[ch].iqsel) == IQSEL_Q)
         |-> $stable(rx_sample_o[ch].i))
         else
         begin
            fail_count++;
            $error("rx_sample_o[%0d].i changed on a Q word", ch);
         end

      a_rx_q_hold : assert property (@(posedge dsp_clk) disable iff (reset_i)
         (!$past(reset_i) && $past(rx_port_i[ch].iqsel) == IQSEL_I)
         |-> $stable(rx_sample_o[ch].q))
         else
         begin
            fail_count++;
            $error("rx_sample_o[%0d].q changed on an I word", ch);
         end
   end

   // Deselected transceivers see no clock
   a_lms1_sclk : assert property (@(posedge dsp_clk)
      spi_sen_n_i[SPI_LMS1] |-> !spi_lms_o[0].sclk)
      else
      begin
         fail_count++;
         $error("First transceiver clocked while deselected");
      end

   a_lms2_sclk : assert property (@(posedge dsp_clk)
      spi_sen_n_i[SPI_LMS2] |-> !spi_lms_o[1].sclk)
      else
      begin
         fail_count++;
         $error("Second transceiver clocked while deselected");
      end

endmodule

bind lms_frontend_top lms_frontend_properties u_props
(
   .dsp_clk     (dsp_clk),
   .reset_i     (reset_i),
   .rx_port_i   (rx_port_i),
   .rx_sample_o (rx_sample_o),
   .tx_port_o   (tx_port_o),
   .spi_sen_n_i (spi_sen_n_i),
   .spi_lms_o   (spi_lms_o)
);

//--- tb_clock_gen.sv
// Testbench clock and reset source
// 10 ns dsp_clk, reset held high for the first three rising edges

`timescale 1ns/1ps

module tb_clock_gen
(
   output logic dsp_clk_o,
   output logic reset_o
);

   localparam int HALF_PERIOD_NS = 5;
   localparam int RESET_CYCLES   = 3;

   initial
   begin
      dsp_clk_o = 1'b0;
      forever #HALF_PERIOD_NS dsp_clk_o = ~dsp_clk_o;
   end

   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk_o);
      #1 reset_o = 1'b0;   // Released just after the third edge
   end

endmodule

//--- lms_frontend_top.sv
// LMS6002D baseband front end
// Receive I/Q demux per channel, shared phase transmit interleaver
// and SPI routing to the clock DAC and both transceivers

`timescale 1ns/1ps

module lms_frontend_top
   import lms_frontend_pkg::*;
(
   input  logic                       dsp_clk,
   input  logic                       reset_i,

   // Receive ports from the transceivers
   input  lms_port_t                  rx_port_i   [NUM_CH],
   output iq_sample_t                 rx_sample_o [NUM_CH],

   // Transmit pairs from the DSP side
   input  iq_sample_t                 tx_sample_i [NUM_CH],
   output lms_port_t                  tx_port_o   [NUM_CH],

   // SPI master side
   input  spi_bus_t                   spi_i,
   input  logic [NUM_SPI_TARGETS-1:0] spi_sen_n_i,
   output logic                       spi_miso_o,

   // SPI target side
   input  logic [NUM_SPI_TARGETS-1:0] spi_target_miso_i,
   output spi_bus_t                   spi_dac_o,
   output spi_bus_t                   spi_lms_o [2]
);

   iq_sample_t rx_sample [NUM_CH];   // Demux outputs
   lms_port_t  tx_port   [NUM_CH];   // Interleaver outputs
   spi_bus_t   spi_dac;
   spi_bus_t   spi_lms [2];
   logic       spi_miso;

   // One demux per receive channel
   for (genvar ch = 0; ch < NUM_CH; ch++)
   begin : g_rx
      lms_rx_iq_demux u_rx_demux
      (
         .dsp_clk  (dsp_clk),
         .reset_i  (reset_i),
         .port_i   (rx_port_i[ch]),
         .sample_o (rx_sample[ch])
      );
   end

   // Both transmit channels share one phase
   lms_tx_iq_interleave u_tx_interleave
   (
      .dsp_clk  (dsp_clk),
      .reset_i  (reset_i),
      .sample_i (tx_sample_i),
      .port_o   (tx_port)
   );

   lms_spi_router u_spi_router
   (
      .spi_i         (spi_i),
      .sen_n_i       (spi_sen_n_i),
      .target_miso_i (spi_target_miso_i),
      .dac_o         (spi_dac),
      .lms_o         (spi_lms),
      .miso_o        (spi_miso)
   );

   assign rx_sample_o = rx_sample;
   assign tx_port_o   = tx_port;
   assign spi_dac_o   = spi_dac;
   assign spi_lms_o   = spi_lms;
   assign spi_miso_o  = spi_miso;

endmodule

//--- lms_spi_router.sv
// SPI target router for the clock DAC and two LMS transceivers
// Gates the shared master clock and data per chip select and
// merges the read back lines of the selected targets

`timescale 1ns/1ps

module lms_spi_router
   import lms_frontend_pkg::*;
(
   input  spi_bus_t                   spi_i,          // From the SPI master
   input  logic [NUM_SPI_TARGETS-1:0] sen_n_i,        // Active low selects
   input  logic [NUM_SPI_TARGETS-1:0] target_miso_i,  // Read back per target
   output spi_bus_t                   dac_o,
   output spi_bus_t                   lms_o [2],
   output logic                       miso_o
);

   logic [NUM_SPI_TARGETS-1:0] sel;   // Active high selects

   assign sel = ~sen_n_i;

   // DAC clock runs free, only its data is gated
   assign dac_o.sclk = spi_i.sclk;
   assign dac_o.mosi = sel[SPI_DAC] ? spi_i.mosi : 1'b0;

   // First transceiver
   always_comb
   begin
      if (sel[SPI_LMS1])
      begin
         lms_o[0] = spi_i;
      end
      else
      begin
         lms_o[0] = '0;   // Held quiet when deselected
      end
   end

   // Second transceiver
   always_comb
   begin
      if (sel[SPI_LMS2])
      begin
         lms_o[1] = spi_i;
      end
      else
      begin
         lms_o[1] = '0;
      end
   end

   // Only selected targets reach the master
   assign miso_o = |(sel & target_miso_i);

endmodule

//--- lms_tx_iq_interleave.sv
// LMS transmit I/Q interleaver
// Drives every transmit port with I then Q words of its held pair,
// using a single half-rate phase so both transceivers stay aligned

`timescale 1ns/1ps

module lms_tx_iq_interleave
   import lms_frontend_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  iq_sample_t sample_i [NUM_CH],  // Pairs from the DSP side
   output lms_port_t  port_o   [NUM_CH]   // Interleaved words to the DACs
);

   logic      phase_q;         // High after an I edge
   logic      phase_next;
   lms_port_t port_q [NUM_CH];
   lms_port_t port_next [NUM_CH];

   // Shared phase toggles every cycle once out of reset
   assign phase_next = ~phase_q;

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         phase_q <= 1'b0;
      end
      else
      begin
         phase_q <= phase_next;
      end
   end

   // Word selection per channel
   // Phase going high sends I, going low sends Q
   always_comb
   begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (phase_next)
         begin
            port_next[ch].d     = sample_i[ch].i;
            port_next[ch].iqsel = IQSEL_I;
         end
         else
         begin
            port_next[ch].d     = sample_i[ch].q;
            port_next[ch].iqsel = IQSEL_Q;
         end
      end
   end

   // Port registers, idle word with Q select in reset
   always_ff @(posedge dsp_clk)
   begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         if (reset_i)
         begin
            port_q[ch] <= TX_PORT_IDLE;
         end
         else
         begin
            port_q[ch] <= port_next[ch];
         end
      end
   end

   assign port_o = port_q;

endmodule

//--- lms_rx_iq_demux.sv
// LMS receive I/Q demultiplexer
// Splits one interleaved receive word stream into separate
// I and Q registers, each held until its next update

`timescale 1ns/1ps

module lms_rx_iq_demux
   import lms_frontend_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  lms_port_t  port_i,   // Interleaved word from the transceiver
   output iq_sample_t sample_o  // Held I/Q pair toward the DSP
);

   logic [SAMPLE_W-1:0] i_q;   // Last I word
   logic [SAMPLE_W-1:0] q_q;   // Last Q word
   logic                is_q;

   // Select bit decides which half is written this edge
   assign is_q = (port_i.iqsel == IQSEL_Q);

   // I register, written only on I words
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         i_q <= '0;
      end
      else if (!is_q)
      begin
         i_q <= port_i.d;
      end
   end

   // Q register, written only on Q words
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         q_q <= '0;
      end
      else if (is_q)
      begin
         q_q <= port_i.d;
      end
   end

   // One cycle from port word to held field
   assign sample_o.i = i_q;
   assign sample_o.q = q_q;

endmodule

//--- lms_frontend_pkg.sv
// LMS transceiver front end shared definitions
// Converter widths, channel count, SPI target indices and the
// bus structs used between the DSP side and the transceivers

package lms_frontend_pkg;

   // Converter word width of the LMS6002D data bus
   localparam int SAMPLE_W = 12;

   // Two transceivers on the board
   localparam int NUM_CH = 2;

   // Clock DAC plus one select per transceiver
   localparam int NUM_SPI_TARGETS = 3;

   // Bit positions within the active low select vector
   localparam int SPI_DAC  = 0;
   localparam int SPI_LMS1 = 1;
   localparam int SPI_LMS2 = 2;

   // One complex sample on the DSP side
   typedef struct packed
   {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
   } iq_sample_t;

   // Interleaved transceiver data port
   // iqsel low marks an I word, high marks a Q word
   typedef struct packed
   {
      logic [SAMPLE_W-1:0] d;
      logic                iqsel;
   } lms_port_t;

   // Shared SPI master lines toward a target
   typedef struct packed
   {
      logic sclk;
      logic mosi;
   } spi_bus_t;

   // Select bit values on the port word
   localparam logic IQSEL_I = 1'b0;
   localparam logic IQSEL_Q = 1'b1;

   // Reset image of a transmit port
   localparam lms_port_t TX_PORT_IDLE = '{d: '0, iqsel: IQSEL_Q};

endpackage
